//--- Makefile
# Verilator build and run for the nora cpu core testbench

VERILATOR ?= verilator
TOP       ?= tb_nora
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- list.f
+incdir+rtl
rtl/cpu_bus_pkg.sv
rtl/nora_slv_pkg.sv
rtl/cpu_phaser.sv
rtl/io_decoder.sv
rtl/simple_via.sv
rtl/sysregs.sv
rtl/nora_core.sv
tests/nora_asserts.sv
tests/nora_checker.sv
tests/tb_nora.sv

//--- rtl/cpu_bus_pkg.sv
// ====================
// cpu side types, imported by the phaser, decoder and slaves
// ====================
`default_nettype none

package cpu_bus_pkg;

    // 16-bit 65xx address
    typedef logic [15:0] cpu_addr_t;

    // one data byte on the cpu bus
    typedef logic [7:0] cpu_byte_t;

    // position inside the six-phase cpu cycle,
    // 0..5 while running, held at 0 when stopped
    typedef logic [2:0] phase_t;

endpackage : cpu_bus_pkg

`default_nettype wire

//--- rtl/cpu_phaser.sv
// ====================
// six-phase cpu clock and bus strobes from clk6x
// run_i stalls the cpu at a cycle boundary
// ====================
`default_nettype none
`include "nora_macros.svh"

module cpu_phaser
    import cpu_bus_pkg::*;
(
    input  logic clk6x,
    input  logic rst_n_i,
    input  logic run_i,             // low = stop at next cycle end
    output logic cpu_phi2_o,
    output logic latch_ad_o,
    output logic setup_cs_o,
    output logic release_wr_o,
    output logic release_cs_o,
    output logic stopped_o
);

    phase_t cnt;                    // current phase
    phase_t cnt_nxt;
    logic   stop_nxt;

    always_comb
    begin
        cnt_nxt  = cnt + phase_t'(1);
        stop_nxt = stopped_o;
        if (cnt == phase_t'(`NORA_PHASE_LEN - 1))
        begin
            cnt_nxt  = '0;          // wrap
            stop_nxt = ~run_i;      // only sample point while running
        end
        else if (stopped_o)
        begin
            // parked at 0, restart straight into count 1
            cnt_nxt  = run_i ? phase_t'(1) : '0;
            stop_nxt = ~run_i;
        end
    end

    // strobes decoded from next count, so they sit on their own count
    always_ff @(posedge clk6x or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            cnt          <= '0;
            stopped_o    <= 1'b1;   // stay parked until run_i
            cpu_phi2_o   <= 1'b0;
            latch_ad_o   <= 1'b0;
            setup_cs_o   <= 1'b0;
            release_wr_o <= 1'b0;
            release_cs_o <= 1'b0;
        end
        else
        begin
            cnt          <= cnt_nxt;
            stopped_o    <= stop_nxt;
            cpu_phi2_o   <= (cnt_nxt >= phase_t'(`NORA_PH_PHI2_RISE));
            latch_ad_o   <= (cnt_nxt == phase_t'(`NORA_PH_LATCH_AD));
            setup_cs_o   <= (cnt_nxt == phase_t'(`NORA_PH_SETUP_CS));
            release_wr_o <= (cnt_nxt == phase_t'(`NORA_PH_RELEASE_WR));
            release_cs_o <= (cnt_nxt == phase_t'(`NORA_PH_RELEASE_CS));
        end
    end

endmodule

`default_nettype wire

//--- rtl/io_decoder.sv
// ====================
// latches the cpu access, selects a slave window,
// commits writes and returns read data on the phaser strobes
// ====================
`default_nettype none
`include "nora_macros.svh"

module io_decoder
    import cpu_bus_pkg::*, nora_slv_pkg::*;
(
    input  logic      clk6x,
    input  logic      rst_n_i,
    input  cpu_addr_t cpu_addr_i,
    input  logic      cpu_rwn_i,        // 1 = read
    input  cpu_byte_t cpu_data_i,
    input  logic      latch_ad_i,
    input  logic      setup_cs_i,
    input  logic      release_wr_i,
    input  logic      release_cs_i,
    input  cpu_byte_t via_rdata_i,      // zero when not selected
    input  cpu_byte_t scrb_rdata_i,
    output cpu_byte_t cpu_data_o,
    output slv_offs_t slv_offs_o,
    output cpu_byte_t slv_wdata_o,
    output logic      slv_wr_valid_o,
    output logic      req_via_o,
    output logic      req_scrb_o
);

    cpu_addr_t   addr_r;                // latched at latch_ad
    logic        rwn_r;
    logic [11:0] addr_win;              // window part of address
    slv_sel_t    sel;
    cpu_byte_t   rd_byte;

    assign addr_win   = addr_r[15:4];
    assign slv_offs_o = addr_r[3:0];

    always_comb
    begin
        if (addr_win == 12'(`NORA_VIA1_BASE >> 4))
            sel = SLV_VIA1;
        else if (addr_win == 12'(`NORA_SCRB_BASE >> 4))
            sel = SLV_SCRB;
        else
            sel = SLV_NONE;
    end

    // slaves already gate their returns, so a plain or is enough
    assign rd_byte = (req_via_o || req_scrb_o) ? (via_rdata_i | scrb_rdata_i)
                                               : cpu_byte_t'(`NORA_UNMAPPED_DATA);

    // address, direction and write data follow the strobes
    always_ff @(posedge clk6x)
    begin
        if (latch_ad_i)
        begin
            addr_r <= cpu_addr_i;
            rwn_r  <= cpu_rwn_i;
        end
        if (release_wr_i && !rwn_r)
            slv_wdata_o <= cpu_data_i;  // cpu data valid late in phi2
    end

    always_ff @(posedge clk6x or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            req_via_o      <= 1'b0;
            req_scrb_o     <= 1'b0;
            slv_wr_valid_o <= 1'b0;
            cpu_data_o     <= cpu_byte_t'(`NORA_UNMAPPED_DATA);
        end
        else
        begin
            slv_wr_valid_o <= release_wr_i && !rwn_r;   // one cycle, lands in count 5
            if (setup_cs_i)
            begin
                req_via_o  <= (sel == SLV_VIA1);
                req_scrb_o <= (sel == SLV_SCRB);
            end
            else if (release_cs_i)
            begin
                req_via_o  <= 1'b0;     // low from count 0
                req_scrb_o <= 1'b0;
            end
            if (release_wr_i && rwn_r)
                cpu_data_o <= rd_byte;  // held until next read
        end
    end

endmodule

`default_nettype wire

//--- rtl/nora_core.sv
// ====================
// cpu side core, phaser drives the decoder which drives the slaves
// ====================
`default_nettype none

module nora_core
    import cpu_bus_pkg::*, nora_slv_pkg::*;
(
    input  logic      clk6x,
    input  logic      rst_n_i,
    input  logic      run_i,
    input  cpu_addr_t cpu_addr_i,
    input  logic      cpu_rwn_i,
    input  cpu_byte_t cpu_data_i,
    input  logic      virq_n_i,
    input  cpu_byte_t gpio_a_i,
    input  cpu_byte_t gpio_b_i,
    output cpu_byte_t cpu_data_o,
    output logic      cpu_phi2_o,
    output logic      stopped_o,
    output logic      cpu_irq_n_o,
    output cpu_byte_t gpio_a_o,
    output cpu_byte_t gpio_a_dir_o,
    output cpu_byte_t gpio_b_o,
    output cpu_byte_t gpio_b_dir_o,
    output cpu_byte_t rambank_mask_o
);

    logic      latch_ad, setup_cs, release_wr, release_cs;  // phaser strobes
    slv_offs_t slv_offs;
    cpu_byte_t slv_wdata;
    logic      slv_wr_valid;
    logic      req_via, req_scrb;
    cpu_byte_t via_rdata, scrb_rdata;   // gated per slave

    cpu_phaser u_phaser (
        .clk6x        (clk6x),
        .rst_n_i      (rst_n_i),
        .run_i        (run_i),
        .cpu_phi2_o   (cpu_phi2_o),
        .latch_ad_o   (latch_ad),
        .setup_cs_o   (setup_cs),
        .release_wr_o (release_wr),
        .release_cs_o (release_cs),
        .stopped_o    (stopped_o)
    );

    io_decoder u_decoder (
        .clk6x          (clk6x),
        .rst_n_i        (rst_n_i),
        .cpu_addr_i     (cpu_addr_i),
        .cpu_rwn_i      (cpu_rwn_i),
        .cpu_data_i     (cpu_data_i),
        .latch_ad_i     (latch_ad),
        .setup_cs_i     (setup_cs),
        .release_wr_i   (release_wr),
        .release_cs_i   (release_cs),
        .via_rdata_i    (via_rdata),
        .scrb_rdata_i   (scrb_rdata),
        .cpu_data_o     (cpu_data_o),
        .slv_offs_o     (slv_offs),
        .slv_wdata_o    (slv_wdata),
        .slv_wr_valid_o (slv_wr_valid),
        .req_via_o      (req_via),
        .req_scrb_o     (req_scrb)
    );

    simple_via u_via1 (
        .clk6x        (clk6x),
        .rst_n_i      (rst_n_i),
        .req_i        (req_via),
        .wr_valid_i   (slv_wr_valid),
        .offs_i       (slv_offs),
        .wdata_i      (slv_wdata),
        .gpio_a_i     (gpio_a_i),
        .gpio_b_i     (gpio_b_i),
        .rdata_o      (via_rdata),
        .gpio_a_o     (gpio_a_o),
        .gpio_a_dir_o (gpio_a_dir_o),
        .gpio_b_o     (gpio_b_o),
        .gpio_b_dir_o (gpio_b_dir_o)
    );

    sysregs u_scrb (
        .clk6x          (clk6x),
        .rst_n_i        (rst_n_i),
        .req_i          (req_scrb),
        .wr_valid_i     (slv_wr_valid),
        .offs_i         (slv_offs),
        .wdata_i        (slv_wdata),
        .virq_n_i       (virq_n_i),
        .rdata_o        (scrb_rdata),
        .rambank_mask_o (rambank_mask_o),
        .cpu_irq_n_o    (cpu_irq_n_o)
    );

endmodule

`default_nettype wire

//--- rtl/nora_macros.svh
// ====================
// bus timing, slave windows and reset values
// include wherever phases or offsets are decoded
// ====================
`ifndef NORA_MACROS_SVH
`define NORA_MACROS_SVH

`define NORA_PHASE_LEN       6          // clk6x cycles per cpu cycle
`define NORA_PH_LATCH_AD     1          // capture address and rwn
`define NORA_PH_SETUP_CS     2          // raise slave request
`define NORA_PH_PHI2_RISE    3          // phi2 high from here to cycle end
`define NORA_PH_RELEASE_WR   4          // write commit / read capture
`define NORA_PH_RELEASE_CS   5          // last count of the access

`define NORA_VIA1_BASE       16'h9F00   // 16-byte windows
`define NORA_SCRB_BASE       16'h9F50

`define NORA_VIA_ORB         0
`define NORA_VIA_ORA         1
`define NORA_VIA_DDRB        2
`define NORA_VIA_DDRA        3
`define NORA_SCRB_RAMBANK    0
`define NORA_SCRB_IRQCTL     1

`define NORA_RAMBANK_RESET   8'h7F      // 128 banks after reset
`define NORA_UNMAPPED_DATA   8'hFF      // idle bus value

`endif

//--- rtl/nora_slv_pkg.sv
// ====================
// internal slave bus types, decoder to via and sysregs
// ====================
`default_nettype none

package nora_slv_pkg;

    // which internal window the latched address hits
    typedef enum logic [1:0] {
        SLV_NONE = 2'd0,        // unmapped, reads return idle value
        SLV_VIA1 = 2'd1,        // gpio block
        SLV_SCRB = 2'd2         // system registers
    } slv_sel_t;

    // register offset, low address nibble
    typedef logic [3:0] slv_offs_t;

endpackage : nora_slv_pkg

`default_nettype wire

//--- rtl/simple_via.sv
// ====================
// reduced 65c22, two gpio ports with direction registers
// sits in the via1 window of the decoder
// ====================
`default_nettype none
`include "nora_macros.svh"

module simple_via
    import cpu_bus_pkg::*, nora_slv_pkg::*;
(
    input  logic      clk6x,
    input  logic      rst_n_i,
    input  logic      req_i,            // window selected
    input  logic      wr_valid_i,       // write commit pulse
    input  slv_offs_t offs_i,
    input  cpu_byte_t wdata_i,
    input  cpu_byte_t gpio_a_i,         // pin levels
    input  cpu_byte_t gpio_b_i,
    output cpu_byte_t rdata_o,
    output cpu_byte_t gpio_a_o,
    output cpu_byte_t gpio_a_dir_o,     // 1 = output
    output cpu_byte_t gpio_b_o,
    output cpu_byte_t gpio_b_dir_o
);

    cpu_byte_t ora, orb;
    cpu_byte_t ddra, ddrb;
    cpu_byte_t port_a, port_b;          // what a port read sees

    always_ff @(posedge clk6x or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            ora  <= '0;
            orb  <= '0;
            ddra <= '0;                 // all pins input
            ddrb <= '0;
        end
        else if (req_i && wr_valid_i)
        begin
            case (offs_i)
                slv_offs_t'(`NORA_VIA_ORB):  orb  <= wdata_i;
                slv_offs_t'(`NORA_VIA_ORA):  ora  <= wdata_i;
                slv_offs_t'(`NORA_VIA_DDRB): ddrb <= wdata_i;
                slv_offs_t'(`NORA_VIA_DDRA): ddra <= wdata_i;
                default: ;              // timers etc. not present
            endcase
        end
    end

    // driven pins read back the register and input pins read the pin level
    assign port_a = (ora & ddra) | (gpio_a_i & ~ddra);
    assign port_b = (orb & ddrb) | (gpio_b_i & ~ddrb);

    always_comb
    begin
        rdata_o = '0;                   // unselected or unused offset
        if (req_i)
        begin
            case (offs_i)
                slv_offs_t'(`NORA_VIA_ORB):  rdata_o = port_b;
                slv_offs_t'(`NORA_VIA_ORA):  rdata_o = port_a;
                slv_offs_t'(`NORA_VIA_DDRB): rdata_o = ddrb;
                slv_offs_t'(`NORA_VIA_DDRA): rdata_o = ddra;
                default:                     rdata_o = '0;
            endcase
        end
    end

    assign gpio_a_o     = ora;
    assign gpio_a_dir_o = ddra;
    assign gpio_b_o     = orb;
    assign gpio_b_dir_o = ddrb;

endmodule

`default_nettype wire

//--- rtl/sysregs.sv
// ====================
// system registers, ram bank mask and irq force/block
// ====================
`default_nettype none
`include "nora_macros.svh"

module sysregs
    import cpu_bus_pkg::*, nora_slv_pkg::*;
(
    input  logic      clk6x,
    input  logic      rst_n_i,
    input  logic      req_i,
    input  logic      wr_valid_i,
    input  slv_offs_t offs_i,
    input  cpu_byte_t wdata_i,
    input  logic      virq_n_i,         // irq from video side, active low
    output cpu_byte_t rdata_o,
    output cpu_byte_t rambank_mask_o,
    output logic      cpu_irq_n_o
);

    logic [1:0] irqctl;                 // [0] force, [1] block

    always_ff @(posedge clk6x or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            rambank_mask_o <= cpu_byte_t'(`NORA_RAMBANK_RESET);
            irqctl         <= '0;
        end
        else if (req_i && wr_valid_i)
        begin
            if (offs_i == slv_offs_t'(`NORA_SCRB_RAMBANK))
                rambank_mask_o <= wdata_i;
            if (offs_i == slv_offs_t'(`NORA_SCRB_IRQCTL))
                irqctl <= wdata_i[1:0];     // upper bits not stored
        end
    end

    always_comb
    begin
        rdata_o = '0;
        if (req_i && offs_i == slv_offs_t'(`NORA_SCRB_RAMBANK))
            rdata_o = rambank_mask_o;
        else if (req_i && offs_i == slv_offs_t'(`NORA_SCRB_IRQCTL))
            rdata_o = {6'b0, irqctl};
    end

    // block wins over both the external line and force
    assign cpu_irq_n_o = ~(~irqctl[1] & (~virq_n_i | irqctl[0]));

endmodule

`default_nettype wire

//--- tests/nora_asserts.sv
// ====================
// phaser strobe and phi2 checks, bound into every cpu_phaser
// ====================
`default_nettype none

module nora_asserts
(
    input  logic clk6x,
    input  logic rst_n_i,
    input  logic cpu_phi2_o,
    input  logic latch_ad_o,
    input  logic setup_cs_o,
    input  logic release_wr_o,
    input  logic release_cs_o,
    input  logic stopped_o
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;                   // failed assertion count

    // every strobe is a single clk6x pulse
    a_latch_pulse: assert property (@(posedge clk6x) disable iff (!rst_n_i)
        latch_ad_o |=> !latch_ad_o)
        else
        begin
            $error("latch_ad longer than one cycle");
            fail_cnt++;
        end
    a_setup_pulse: assert property (@(posedge clk6x) disable iff (!rst_n_i)
        setup_cs_o |=> !setup_cs_o)
        else
        begin
            $error("setup_cs longer than one cycle");
            fail_cnt++;
        end
    a_relwr_pulse: assert property (@(posedge clk6x) disable iff (!rst_n_i)
        release_wr_o |=> !release_wr_o)
        else
        begin
            $error("release_wr longer than one cycle");
            fail_cnt++;
        end
    a_relcs_pulse: assert property (@(posedge clk6x) disable iff (!rst_n_i)
        release_cs_o |=> !release_cs_o)
        else
        begin
            $error("release_cs longer than one cycle");
            fail_cnt++;
        end

    // strobe order inside one cpu cycle at counts 1, 2, 4 and 5
    a_order_setup: assert property (@(posedge clk6x) disable iff (!rst_n_i)
        latch_ad_o |=> setup_cs_o)
        else
        begin
            $error("setup_cs did not follow latch_ad");
            fail_cnt++;
        end
    a_order_relwr: assert property (@(posedge clk6x) disable iff (!rst_n_i)
        setup_cs_o |=> !release_wr_o ##1 release_wr_o)
        else
        begin
            $error("release_wr out of order");
            fail_cnt++;
        end
    a_order_relcs: assert property (@(posedge clk6x) disable iff (!rst_n_i)
        release_wr_o |=> release_cs_o)
        else
        begin
            $error("release_cs did not follow release_wr");
            fail_cnt++;
        end

    a_stop_phi2: assert property (@(posedge clk6x) disable iff (!rst_n_i)
        stopped_o |-> !cpu_phi2_o)
        else
        begin
            $error("phi2 high while stopped");
            fail_cnt++;
        end

endmodule

bind cpu_phaser nora_asserts u_asserts (
    .clk6x        (clk6x),
    .rst_n_i      (rst_n_i),
    .cpu_phi2_o   (cpu_phi2_o),
    .latch_ad_o   (latch_ad_o),
    .setup_cs_o   (setup_cs_o),
    .release_wr_o (release_wr_o),
    .release_cs_o (release_cs_o),
    .stopped_o    (stopped_o)
);

`default_nettype wire

//--- tests/nora_checker.sv
// ====================
// watches the core ports, models the registers and compares
// ====================
`default_nettype none
`include "nora_macros.svh"

module nora_checker
    import cpu_bus_pkg::*;
(
    input  logic      clk6x,
    input  logic      rst_n_i,
    input  logic      run_i,
    input  cpu_addr_t cpu_addr_i,
    input  logic      cpu_rwn_i,
    input  cpu_byte_t cpu_data_i,
    input  logic      virq_n_i,
    input  cpu_byte_t gpio_a_i,
    input  cpu_byte_t gpio_b_i,
    input  cpu_byte_t cpu_data_o,
    input  logic      cpu_phi2_o,
    input  logic      stopped_o,
    input  logic      cpu_irq_n_o,
    input  cpu_byte_t gpio_a_o,
    input  cpu_byte_t gpio_a_dir_o,
    input  cpu_byte_t gpio_b_o,
    input  cpu_byte_t gpio_b_dir_o,
    input  cpu_byte_t rambank_mask_o,
    input  logic      test_end_i,       // toggles once per finished test
    input  int        test_id_i,
    input  logic      all_done_i,
    output int        err_cnt_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF = `NORA_PHASE_LEN / 2;  // clk6x cycles per phi2 level

    cpu_byte_t  m_ora, m_orb, m_ddra, m_ddrb;   // model of via
    cpu_byte_t  m_bank;                         // model of sysregs
    logic [1:0] m_ctl;
    int         hi_len, lo_len;
    logic       lo_stop;                        // stopped seen in this low phase
    logic       exp_stop;
    int         errs, rst_errs, base_errs, n_checks;

    assign err_cnt_o = errs + rst_errs;

    // expected read byte for an access, from model state and pin levels
    function automatic cpu_byte_t ref_read(cpu_addr_t a, cpu_byte_t pa, cpu_byte_t pb);
        cpu_byte_t r;
        r = `NORA_UNMAPPED_DATA;
        if ((a & 16'hFFF0) == `NORA_VIA1_BASE)
        begin
            r = '0;
            case (int'(a[3:0]))
                `NORA_VIA_ORB:  for (int i = 0; i < 8; i++) r[i] = m_ddrb[i] ? m_orb[i] : pb[i];
                `NORA_VIA_ORA:  for (int i = 0; i < 8; i++) r[i] = m_ddra[i] ? m_ora[i] : pa[i];
                `NORA_VIA_DDRB: r = m_ddrb;
                `NORA_VIA_DDRA: r = m_ddra;
                default:        r = '0;
            endcase
        end
        else if ((a & 16'hFFF0) == `NORA_SCRB_BASE)
        begin
            r = '0;
            if (int'(a[3:0]) == `NORA_SCRB_RAMBANK)
                r = m_bank;
            else if (int'(a[3:0]) == `NORA_SCRB_IRQCTL)
                r = {6'b0, m_ctl};
        end
        return r;
    endfunction

    // block bit wins, otherwise either source pulls irq low
    function automatic logic ref_irq_n(logic virq_n, logic [1:0] ctl);
        if (ctl[1])
            return 1'b1;
        return !(!virq_n || ctl[0]);
    endfunction

    function automatic string test_name(int id);
        case (id)
            1:       return "clock shape";
            2:       return "stop and resume";
            3:       return "via ports";
            4:       return "system registers";
            5:       return "irq rule";
            6:       return "unmapped reads";
            default: return "unknown";
        endcase
    endfunction

    task automatic bad_value(string what, int got, int exp);
        $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        errs++;
    endtask

    // count 5 of an access, phi2 high for the third time
    task automatic check_access();
        cpu_byte_t exp;
        if (cpu_rwn_i)
        begin
            exp = ref_read(cpu_addr_i, gpio_a_i, gpio_b_i);
            if (cpu_data_o !== exp)
                bad_value($sformatf("read %h", cpu_addr_i), cpu_data_o, exp);
        end
        if (gpio_a_o !== m_ora)      bad_value("gpio_a_o", gpio_a_o, m_ora);
        if (gpio_b_o !== m_orb)      bad_value("gpio_b_o", gpio_b_o, m_orb);
        if (gpio_a_dir_o !== m_ddra) bad_value("gpio_a_dir_o", gpio_a_dir_o, m_ddra);
        if (gpio_b_dir_o !== m_ddrb) bad_value("gpio_b_dir_o", gpio_b_dir_o, m_ddrb);
        if (rambank_mask_o !== m_bank) bad_value("rambank_mask_o", rambank_mask_o, m_bank);
        if (cpu_irq_n_o !== ref_irq_n(virq_n_i, m_ctl))
            bad_value("cpu_irq_n_o", cpu_irq_n_o, ref_irq_n(virq_n_i, m_ctl));
        // write lands in the registers at the end of this count
        if (!cpu_rwn_i && (cpu_addr_i & 16'hFFF0) == `NORA_VIA1_BASE)
        begin
            case (int'(cpu_addr_i[3:0]))
                `NORA_VIA_ORB:  m_orb  = cpu_data_i;
                `NORA_VIA_ORA:  m_ora  = cpu_data_i;
                `NORA_VIA_DDRB: m_ddrb = cpu_data_i;
                `NORA_VIA_DDRA: m_ddra = cpu_data_i;
                default: ;
            endcase
        end
        else if (!cpu_rwn_i && (cpu_addr_i & 16'hFFF0) == `NORA_SCRB_BASE)
        begin
            if (int'(cpu_addr_i[3:0]) == `NORA_SCRB_RAMBANK) m_bank = cpu_data_i;
            if (int'(cpu_addr_i[3:0]) == `NORA_SCRB_IRQCTL)  m_ctl  = cpu_data_i[1:0];
        end
        exp_stop = !run_i;                          // run sampled here only
        n_checks++;
    endtask

    initial
    begin
        errs      = 0;
        rst_errs  = 0;
        base_errs = 0;
        n_checks  = 0;
    end

    // outputs settle on posedge, inputs change on negedge in count 0 only
    always @(negedge clk6x)
    begin
        if (!rst_n_i)
        begin
            m_ora = '0;  m_orb = '0;  m_ddra = '0;  m_ddrb = '0;
            m_bank = `NORA_RAMBANK_RESET;
            m_ctl = '0;
            hi_len = 0;  lo_len = 0;  lo_stop = 1'b1;  exp_stop = 1'b1;
        end
        else if (cpu_phi2_o)
        begin
            if (stopped_o)
                bad_value("stopped_o during phi2 high", stopped_o, 0);
            if (lo_len > 0 && !lo_stop && lo_len != HALF)
                $display("ERR %0t: phi2 low for %0d cycles without a stop", $time, lo_len);
            if (lo_len > 0 && !lo_stop && lo_len != HALF)
                errs++;
            lo_len = 0;
            lo_stop = 1'b0;
            hi_len++;
            if (hi_len == HALF)
                check_access();
        end
        else
        begin
            if (hi_len > 0 && hi_len != HALF)
                bad_value("phi2 high length", hi_len, HALF);
            hi_len = 0;
            lo_len++;
            if (lo_len == 1 && stopped_o !== exp_stop)
                bad_value("stopped_o after cycle end", stopped_o, exp_stop);
            if (stopped_o)
                lo_stop = 1'b1;
        end
    end

    always @(posedge rst_n_i)
    begin
        if (stopped_o !== 1'b1 || cpu_phi2_o !== 1'b0)
            rst_errs++;
        if (rambank_mask_o !== `NORA_RAMBANK_RESET || cpu_data_o !== `NORA_UNMAPPED_DATA)
            rst_errs++;
        if (rst_errs != 0)
            $display("ERR %0t: outputs wrong at reset release", $time);
    end

    always @(test_end_i)
    begin
        if (test_id_i != 0)
        begin
            $display("test %0d %s: %0d errors", test_id_i, test_name(test_id_i),
                     errs - base_errs);
            base_errs = errs;
        end
    end

    always @(posedge all_done_i)
        $display("accesses checked %0d, errors %0d", n_checks, errs + rst_errs);

endmodule

`default_nettype wire

//--- tests/tb_nora.sv
// ====================
// testbench for nora_core, drives cpu accesses, checker compares
// ====================
`default_nettype none
`include "nora_macros.svh"

module tb_nora
    import cpu_bus_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD     = 8;
    localparam int PLANNED_CYCLES = 80;     // about 60 accesses plus stall time
    localparam int MARGIN_NS      = 2000;

    logic      clk6x, rst_n_i, run_i, cpu_rwn_i, virq_n_i;
    cpu_addr_t cpu_addr_i;
    cpu_byte_t cpu_data_i, gpio_a_i, gpio_b_i;
    cpu_byte_t cpu_data_o, gpio_a_o, gpio_a_dir_o, gpio_b_o, gpio_b_dir_o, rambank_mask_o;
    logic      cpu_phi2_o, stopped_o, cpu_irq_n_o;
    logic      test_end, all_done;
    int        test_id, err_cnt;
    integer    seed = 32'haf674319;

    nora_core DUT (.*);

    nora_checker u_checker (
        .test_end_i (test_end),
        .test_id_i  (test_id),
        .all_done_i (all_done),
        .err_cnt_o  (err_cnt),
        .*
    );

    initial
    begin
        clk6x = 1'b0;
        forever #(CLK_PERIOD / 2) clk6x = ~clk6x;
    end

    // starts in count 0 on a falling edge, returns at the next one
    task automatic cpu_access(cpu_addr_t a, logic rwn, cpu_byte_t d);
        cpu_addr_i = a;
        cpu_rwn_i  = rwn;
        cpu_data_i = d;
        gpio_a_i   = 8'($random(seed));     // fresh pin levels each cycle
        gpio_b_i   = 8'($random(seed));
        @(negedge cpu_phi2_o);
        @(negedge clk6x);
    endtask

    task automatic write_reg(cpu_addr_t a, cpu_byte_t d);
        cpu_access(a, 1'b0, d);
    endtask

    task automatic read_reg(cpu_addr_t a);
        cpu_access(a, 1'b1, 8'($random(seed)));  // data ignored on reads
    endtask

    task automatic end_test(int id);
        test_id  = id;
        test_end = ~test_end;
    endtask

    initial
    begin
        rst_n_i = 1'b0;  run_i = 1'b0;  virq_n_i = 1'b1;
        cpu_addr_i = '0;  cpu_rwn_i = 1'b1;  cpu_data_i = '0;
        gpio_a_i = '0;  gpio_b_i = '0;
        test_end = 1'b0;  test_id = 0;  all_done = 1'b0;
        repeat (2) @(negedge clk6x);
        rst_n_i = 1'b1;
        @(negedge clk6x);

        run_i = 1'b1;                       // parked at count 0, go
        repeat (4) read_reg(16'h0000);
        end_test(1);

        run_i = 1'b0;                       // this cycle still completes
        read_reg(16'h0000);
        repeat (5) @(negedge clk6x);
        run_i = 1'b1;
        repeat (2) read_reg(16'h0000);
        end_test(2);

        repeat (12)
        begin
            write_reg(`NORA_VIA1_BASE | 16'($random(seed) & 3), 8'($random(seed)));
            read_reg(`NORA_VIA1_BASE | 16'($random(seed) & 3));
        end
        end_test(3);

        read_reg(16'(`NORA_SCRB_BASE | `NORA_SCRB_RAMBANK));     // reset value first
        write_reg(16'(`NORA_SCRB_BASE | `NORA_SCRB_RAMBANK), 8'($random(seed)));
        read_reg(16'(`NORA_SCRB_BASE | `NORA_SCRB_RAMBANK));
        read_reg(16'(`NORA_SCRB_BASE | `NORA_SCRB_IRQCTL));
        end_test(4);

        for (int v = 0; v < 2; v++)
        begin
            for (int c = 0; c < 4; c++)
            begin
                write_reg(16'(`NORA_SCRB_BASE | `NORA_SCRB_IRQCTL), 8'(c));
                virq_n_i = v[0];
                read_reg(16'(`NORA_SCRB_BASE | `NORA_SCRB_IRQCTL));
            end
        end
        virq_n_i = 1'b1;
        write_reg(16'(`NORA_SCRB_BASE | `NORA_SCRB_IRQCTL), 8'h00);
        end_test(5);

        read_reg(16'h1234);
        read_reg(16'hFFFF);
        read_reg(`NORA_VIA1_BASE | 16'h0007);   // unused via offsets
        read_reg(`NORA_SCRB_BASE | 16'h000A);
        end_test(6);

        all_done = 1'b1;
        repeat (2) @(negedge clk6x);
        if (err_cnt == 0 && DUT.u_phaser.u_asserts.fail_cnt == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    initial
    begin
        #(PLANNED_CYCLES * `NORA_PHASE_LEN * CLK_PERIOD + MARGIN_NS);
        $display("timeout: the cpu cycles did not complete in the expected time");
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire
